// File: hdl/mul_pkg.sv
`default_nettype none

package mul_pkg;

    // operand and result widths
    typedef logic [31:0] mul_operand_t;   // one source operand
    typedef logic [63:0] mul_product_t;   // full-width product
    typedef logic [3:0]  mul_tag_t;       // returned unchanged with the result

    // one multiply request, 69 bits
    typedef struct packed {
        mul_operand_t op1;        // multiplicand
        mul_operand_t op2;        // multiplier
        logic         is_signed;  // low for unsigned multiply
        mul_tag_t     tag;
    } mul_req_t;

    // one multiply result, 68 bits
    typedef struct packed {
        mul_product_t product;
        mul_tag_t     tag;
    } mul_resp_t;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        RUN,
        FIX,
        ISSUE
    } mul_seq_state_t;

endpackage

`default_nettype wire

// File: hdl/mul_req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module mul_req_fifo #(
    parameter int REQ_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    input  mul_pkg::mul_req_t req,
    input  logic              pop,
    output mul_pkg::mul_req_t head,
    output logic              fifo_empty,
    output logic              req_credit
);

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(REQ_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(REQ_DEPTH);

    mul_pkg::mul_req_t entries [REQ_DEPTH];  // request storage
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;                // occupied entries
    logic              full;

    assign full       = (count == FULL_CNT);
    assign fifo_empty = (count == '0);
    assign head       = entries[rd_ptr];     // visible the cycle after the write

    always_ff @(posedge clk)
    begin
        if (req_valid)
        begin
            entries[wr_ptr] <= req;          // every credited send is accepted
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (req_valid)
            begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else
        begin
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // idle, or write and pop together
            endcase
        end
    end

    // one credit back upstream per popped entry
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            req_credit <= 1'b0;
        end
        else
        begin
            req_credit <= pop;
        end
    end

    // a write into a full buffer means upstream sent without holding a credit
    a_no_overspend: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> !full)
        else $error("request written into full buffer, upstream overspent credits");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> !fifo_empty)
        else $error("pop from empty request buffer");

endmodule

`default_nettype wire

// File: hdl/mul_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mul_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic fifo_empty,
    input  logic mplier_zero,
    input  logic credit_avail,
    output logic pop,
    output logic load,
    output logic step,
    output logic fix,
    output logic credit_spend,
    output logic resp_valid
);

    mul_pkg::mul_seq_state_t state;
    mul_pkg::mul_seq_state_t state_next;
    logic                    issue_pulse;   // registered result strobe

    always_comb
    begin
        state_next = state;
        case (state)
            mul_pkg::IDLE:
            begin
                if (!fifo_empty)
                begin
                    state_next = mul_pkg::LOAD;
                end
            end
            mul_pkg::LOAD:
            begin
                state_next = mul_pkg::RUN;      // operands captured this cycle
            end
            mul_pkg::RUN:
            begin
                if (mplier_zero)
                begin
                    state_next = mul_pkg::FIX;  // early exit, no bits left
                end
            end
            mul_pkg::FIX:
            begin
                state_next = mul_pkg::ISSUE;
            end
            mul_pkg::ISSUE:
            begin
                if (credit_avail)
                begin
                    state_next = mul_pkg::IDLE;
                end
            end
            default:
            begin
                state_next = mul_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= mul_pkg::IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // head is still valid in LOAD, so capture and pop go together
    assign pop  = (state == mul_pkg::LOAD);
    assign load = (state == mul_pkg::LOAD);
    assign step = (state == mul_pkg::RUN) && !mplier_zero;
    assign fix  = (state == mul_pkg::FIX);

    // the credit seen in ISSUE cannot be taken by anyone else before the pulse
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            issue_pulse <= 1'b0;
        end
        else
        begin
            issue_pulse <= (state == mul_pkg::ISSUE) && credit_avail;
        end
    end

    assign resp_valid   = issue_pulse;  // to downstream
    assign credit_spend = issue_pulse;  // to the credit counter

    a_issue_with_credit: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> credit_avail)
        else $error("response issued without a response credit");

endmodule

`default_nettype wire

// File: hdl/mul_credit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module mul_credit_counter #(
    parameter int RESP_CREDITS = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic spend,
    input  logic credit_return,
    output logic credit_avail
);

    localparam int CNT_W = $clog2(RESP_CREDITS + 1);
    localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(RESP_CREDITS);

    logic [CNT_W-1:0] count;    // response credits held

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= MAX_CNT;   // unit owns all credits after reset
        end
        else
        begin
            case ({credit_return, spend})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign credit_avail = (count != '0);

    // downstream handed back more credits than it was ever given
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (credit_return && !spend) |-> (count < MAX_CNT))
        else $error("response credit returned beyond the initial count");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        spend |-> (count != '0))
        else $error("response credit spent at zero");

endmodule

`default_nettype wire

// File: hdl/mul_shift_add.sv
`timescale 1ns/1ps
`default_nettype none

module mul_shift_add (
    input  logic               clk,
    input  logic               reset,
    input  logic               load,
    input  logic               step,
    input  logic               fix,
    input  mul_pkg::mul_req_t  head,
    output logic               mplier_zero,
    output mul_pkg::mul_resp_t resp
);

    logic                  op1_neg;
    logic                  op2_neg;
    mul_pkg::mul_operand_t op1_mag;
    mul_pkg::mul_operand_t op2_mag;

    mul_pkg::mul_product_t multiplicand;   // shifts left each step
    mul_pkg::mul_operand_t multiplier;     // shifts right each step
    mul_pkg::mul_product_t accum;          // unsigned partial sum
    logic                  prod_neg;
    mul_pkg::mul_tag_t     tag;

    // sign bits only count in signed mode
    assign op1_neg = head.is_signed & head.op1[31];
    assign op2_neg = head.is_signed & head.op2[31];

    // most negative operand maps to 2**31, fine as unsigned
    assign op1_mag = op1_neg ? (~head.op1 + 1'b1) : head.op1;
    assign op2_mag = op2_neg ? (~head.op2 + 1'b1) : head.op2;

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            multiplicand <= {32'd0, op1_mag};
        end
        else if (step)
        begin
            multiplicand <= {multiplicand[62:0], 1'b0};
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            multiplier <= '0;
        end
        else if (load)
        begin
            multiplier <= op2_mag;
        end
        else if (step)
        begin
            multiplier <= {1'b0, multiplier[31:1]};
        end
    end

    assign mplier_zero = (multiplier == '0);  // no set bits left to add

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            accum <= '0;
        end
        else if (step && multiplier[0])
        begin
            accum <= accum + multiplicand;   // partial product for this bit
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            prod_neg <= op1_neg ^ op2_neg;
            tag      <= head.tag;
        end
    end

    // result stays put until the next fix, so it holds through ISSUE
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            resp <= '0;
        end
        else if (fix)
        begin
            resp.product <= prod_neg ? (~accum + 1'b1) : accum;
            resp.tag     <= tag;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mul_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit_top #(
    parameter int REQ_DEPTH    = 4,
    parameter int RESP_CREDITS = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_valid,
    input  mul_pkg::mul_req_t  req,
    output logic               req_credit,
    output logic               resp_valid,
    output mul_pkg::mul_resp_t resp,
    input  logic               resp_credit
);

    logic              fifo_empty;
    mul_pkg::mul_req_t head;          // oldest pending request
    logic              pop;
    logic              load;
    logic              step;
    logic              fix;
    logic              mplier_zero;
    logic              credit_avail;
    logic              credit_spend;

    mul_req_fifo #(
        .REQ_DEPTH (REQ_DEPTH)
    ) mul_req_fifo_inst (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .pop        (pop),
        .head       (head),
        .fifo_empty (fifo_empty),
        .req_credit (req_credit)
    );

    mul_sequencer mul_sequencer_inst (
        .clk          (clk),
        .reset        (reset),
        .fifo_empty   (fifo_empty),
        .mplier_zero  (mplier_zero),
        .credit_avail (credit_avail),
        .pop          (pop),
        .load         (load),
        .step         (step),
        .fix          (fix),
        .credit_spend (credit_spend),
        .resp_valid   (resp_valid)
    );

    mul_credit_counter #(
        .RESP_CREDITS (RESP_CREDITS)
    ) mul_credit_counter_inst (
        .clk           (clk),
        .reset         (reset),
        .spend         (credit_spend),
        .credit_return (resp_credit),
        .credit_avail  (credit_avail)
    );

    mul_shift_add mul_shift_add_inst (
        .clk         (clk),
        .reset       (reset),
        .load        (load),
        .step        (step),
        .fix         (fix),
        .head        (head),
        .mplier_zero (mplier_zero),
        .resp        (resp)
    );

endmodule

`default_nettype wire

// File: verif/mul_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit_tb;

    localparam int REQ_DEPTH    = 4;
    localparam int RESP_CREDITS = 2;
    localparam int NUM_CORNERS  = 11;
    localparam int NUM_RANDOM   = 40;
    localparam int NUM_BP       = 6;
    localparam int NUM_REQS     = 2 * NUM_CORNERS + NUM_RANDOM + NUM_BP;
    localparam int LIMIT_CYCLES = NUM_REQS * (REQ_DEPTH + 40) + 1000;

    logic               clk;
    logic               reset;
    logic               req_valid;
    mul_pkg::mul_req_t  req;
    logic               req_credit;
    logic               resp_valid;
    mul_pkg::mul_resp_t resp;
    logic               resp_credit;

    int                 up_credits;     // request credits held upstream
    int                 owed;           // response credits not yet handed back
    bit                 hold_credits;   // downstream withholds its returns
    logic [15:0]        lfsr;
    mul_pkg::mul_req_t  exp_q [$];      // sent requests, oldest first
    mul_pkg::mul_resp_t resp_q [$];     // responses seen downstream

    // {op1, op2} bit patterns, used in both signed and unsigned mode
    logic [63:0] corners [NUM_CORNERS] = '{
        64'h00000000_00000000, 64'h00000001_00000001, 64'hffffffff_ffffffff,
        64'hffffffff_00000001, 64'h80000000_80000000, 64'h80000000_ffffffff,
        64'h7fffffff_7fffffff, 64'h7fffffff_80000000, 64'hfffffffb_00000007,
        64'h00003039_fffffd5a, 64'hffffffff_00000000
    };

    mul_unit_top #(
        .REQ_DEPTH    (REQ_DEPTH),
        .RESP_CREDITS (RESP_CREDITS)
    ) mul_unit_top_inst (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .resp_credit (resp_credit)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: tests did not complete within %0d clock cycles", LIMIT_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    // upstream credit model and downstream sink, sampled mid-cycle
    initial
    begin
        resp_credit = 1'b0;
        forever
        begin
            @(negedge clk);
            if (!reset && req_credit)
                up_credits = up_credits + 1;
            if (!reset && resp_valid)
            begin
                resp_q.push_back(resp);
                owed = owed + 1;
            end
            @(posedge clk);
            #1;
            resp_credit = !reset && !hold_credits && (owed > 0);  // one return per cycle
            if (resp_credit)
                owed = owed - 1;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        repeat (n)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};    // x^16 + x^14 + x^13 + x^11 + 1
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // extended operands, so the low 64 bits are the exact product
    function automatic mul_pkg::mul_product_t ref_product(input mul_pkg::mul_req_t r);
        mul_pkg::mul_product_t a;
        mul_pkg::mul_product_t b;
        a = r.is_signed ? {{32{r.op1[31]}}, r.op1} : {32'd0, r.op1};
        b = r.is_signed ? {{32{r.op2[31]}}, r.op2} : {32'd0, r.op2};
        return a * b;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // spends one upstream credit, waiting for one if none is held
    task automatic send_req(input mul_pkg::mul_req_t r);
        while (up_credits == 0)
            wait_cycles(1);
        req_valid  = 1'b1;
        req        = r;
        up_credits = up_credits - 1;
        exp_q.push_back(r);
        wait_cycles(1);
        req_valid = 1'b0;
    endtask

    task automatic drain_and_check(input int n, input string name);
        mul_pkg::mul_req_t  sent;
        mul_pkg::mul_resp_t got;
        int                 i;
        for (i = 0; i < n; i++)
        begin
            while (resp_q.size() == 0)
                wait_cycles(1);
            sent = exp_q.pop_front();
            got  = resp_q.pop_front();
            check_equal(got.product, ref_product(sent), $sformatf("%s product %0d", name, i));
            check_equal(64'(got.tag), 64'(sent.tag), $sformatf("%s tag %0d", name, i));
        end
    endtask

    task automatic send_corners(input logic is_signed);
        mul_pkg::mul_req_t r;
        int                i;
        for (i = 0; i < NUM_CORNERS; i++)
        begin
            r.op1       = corners[i][63:32];
            r.op2       = corners[i][31:0];
            r.is_signed = is_signed;
            r.tag       = 4'(i);
            send_req(r);
        end
    endtask

    task automatic send_random(input int n);
        mul_pkg::mul_req_t r;
        logic [31:0]       shift;
        int                i;
        for (i = 0; i < n; i++)
        begin
            r.op1       = rand_bits(32);
            shift       = rand_bits(5);
            r.op2       = rand_bits(32) >> shift;   // spreads the run length
            r.is_signed = (rand_bits(1) == 32'd1);
            r.tag       = 4'(i);
            send_req(r);
        end
    endtask

    task automatic test_reset_state();
        int i;
        for (i = 0; i < 8; i++)
        begin
            @(negedge clk);
            check_equal(64'(resp_valid), 64'd0, "resp_valid high while idle after reset");
            check_equal(64'(req_credit), 64'd0, "req_credit high while idle after reset");
        end
        wait_cycles(1);
    endtask

    task automatic test_signed_corners();
        send_corners(1'b1);
        drain_and_check(NUM_CORNERS, "signed corner");
    endtask

    task automatic test_unsigned_mode();
        send_corners(1'b0);
        drain_and_check(NUM_CORNERS, "unsigned corner");
    endtask

    task automatic test_random_stream();
        send_random(NUM_RANDOM);
        drain_and_check(NUM_RANDOM, "random stream");
        wait_cycles(2);
        check_equal(64'(up_credits), 64'(REQ_DEPTH), "request credits after random stream");
    endtask

    task automatic test_backpressure();
        int held;
        wait_cycles(4);                 // pending returns settle first
        hold_credits = 1'b1;
        send_random(NUM_BP);
        wait_cycles(200);
        check_equal(64'(resp_q.size() <= RESP_CREDITS), 64'd1,
                    "more responses than response credits");
        // stalled unit holds one request in the datapath and the rest in the buffer
        check_equal(64'(up_credits + exp_q.size() - resp_q.size()), 64'(REQ_DEPTH + 1),
                    "request credits not matched to requests held while stalled");
        held = up_credits;
        wait_cycles(40);
        check_equal(64'(up_credits), 64'(held), "request credit returned while stalled");
        hold_credits = 1'b0;
        drain_and_check(NUM_BP, "backpressure");
        wait_cycles(4);
        check_equal(64'(up_credits), 64'(REQ_DEPTH), "request credits after backpressure");
    endtask

    initial
    begin
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        up_credits = REQ_DEPTH;
        lfsr       = 16'd81;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_signed_corners();
        test_unsigned_mode();
        test_random_stream();
        test_backpressure();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/mul_pkg.sv
hdl/mul_req_fifo.sv
hdl/mul_sequencer.sv
hdl/mul_credit_counter.sv
hdl/mul_shift_add.sv
hdl/mul_unit_top.sv
verif/mul_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mul_unit_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
